//--- ringBusPkg.sv
// Ring bus message format, opcodes and node ids.
// Shared by every ring stop and by the testbench.
package ringBusPkg;

	// low byte of opm, bits 7:6 == 01 marks a response
	localparam logic [7:0] ringOpmIdle = 8'h00;
	localparam logic [7:0] ringOpmLdsq = 8'h93; // load quad
	localparam logic [7:0] ringOpmStsq = 8'hA3; // store quad
	localparam logic [7:0] ringOpmLdsl = 8'h92; // load long
	localparam logic [7:0] ringOpmStsl = 8'hA2; // store long
	localparam logic [7:0] ringOpmOkld = 8'h60; // ok-load response

	localparam logic [7:0] requesterNodeId = 8'h04;

	localparam int ringTagCount = 4;
	localparam int ringTagBits = $clog2(ringTagCount);

	typedef struct packed
	{
		logic [15:0] seq; // node id : tag
		logic [15:0] opm;
		logic [31:0] addr;
		logic [63:0] data;
	} ringMsg_t;

	localparam ringMsg_t ringMsgIdle = '{
		seq: 16'h0000,
		opm: {8'h00, ringOpmIdle},
		addr: 32'h0000_0000,
		data: 64'h0
	};

	typedef struct packed
	{
		logic        write;
		logic        isLong; // 32-bit access
		logic [31:0] addr;
		logic [63:0] data;
	} ringCmd_t;

	typedef struct packed
	{
		logic [7:0]  tag;
		logic [63:0] data;
	} ringRsp_t;

endpackage

//--- mmioBusPkg.sv
// MMIO bus handshake codes and the register bank layout.
// Used by the ring bridge, the register bank and the top level.
package mmioBusPkg;

	// request opm, ready means no request
	localparam logic [4:0] mmioOpmReady = 5'h00;
	localparam logic [4:0] mmioOpmRdL = 5'h0A;
	localparam logic [4:0] mmioOpmRdQ = 5'h0B;
	localparam logic [4:0] mmioOpmWrL = 5'h12;
	localparam logic [4:0] mmioOpmWrQ = 5'h13;

	// device answer
	localparam logic [1:0] mmioOkReady = 2'b00;
	localparam logic [1:0] mmioOkOk = 2'b01;
	localparam logic [1:0] mmioOkHold = 2'b10;

	typedef struct packed
	{
		logic [4:0]  opm;
		logic [31:0] addr;
		logic [63:0] data;
	} mmioReq_t;

	localparam logic [19:0] mmioBankBase = 20'hF0001; // addr[31:12]
	localparam int mmioRegCount = 16;
	localparam int mmioRegIdxBits = $clog2(mmioRegCount); // selects from addr[6:3]
	localparam int mmioMaxDelay = 4;

endpackage

//--- ringRequester.sv
// Requester stop on the ring: tags incoming commands, puts them on the ring
// and pulls responses addressed to this node back off it.
`timescale 1ns/10ps

module ringRequester
	import ringBusPkg::*;
(
	input logic clock,
	input logic reset,
	input logic cmdValid,
	input ringCmd_t cmd,
	output logic cmdReady,
	output ringRsp_t rsp,
	output logic rspValid,
	input ringMsg_t ringIn,
	output ringMsg_t ringOut
);

	logic [ringTagCount-1:0] outstanding; // one bit per tag in flight
	logic [7:0] freeTag;
	logic tagFree;
	logic inIdle;
	logic isOwnRsp;
	logic accept;
	logic [7:0] cmdOpcode;
	ringMsg_t cmdMsg;

	assign inIdle = ringIn.opm[7:0] == ringOpmIdle;
	assign isOwnRsp = (ringIn.opm[7:6] == 2'b01) && (ringIn.seq[15:8] == requesterNodeId);

	// lowest free tag wins
	always_comb
	begin
		freeTag = 8'h00;
		tagFree = 1'b0;
		for (int i = ringTagCount - 1; i >= 0; i--)
		begin
			if (!outstanding[i])
			begin
				freeTag = 8'(i);
				tagFree = 1'b1;
			end
		end
	end

	assign cmdReady = tagFree && inIdle;
	assign accept = cmdValid && cmdReady;

	always_comb
	begin
		if (cmd.write)
			cmdOpcode = cmd.isLong ? ringOpmStsl : ringOpmStsq;
		else
			cmdOpcode = cmd.isLong ? ringOpmLdsl : ringOpmLdsq;
	end

	assign cmdMsg.seq = {requesterNodeId, freeTag};
	assign cmdMsg.opm = {8'h00, cmdOpcode};
	assign cmdMsg.addr = cmd.addr;
	assign cmdMsg.data = cmd.data;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			outstanding <= '0;
			rspValid <= 1'b0;
			ringOut <= ringMsgIdle;
		end
		else
		begin
			if (accept)
				outstanding[freeTag[ringTagBits-1:0]] <= 1'b1;
			if (isOwnRsp)
				outstanding[ringIn.seq[ringTagBits-1:0]] <= 1'b0; // tag returns to pool
			rspValid <= isOwnRsp;

			if (accept)
				ringOut <= cmdMsg;
			else if (isOwnRsp)
				ringOut <= ringMsgIdle; // response consumed, slot freed
			else
				ringOut <= ringIn;
		end
	end

	always_ff @(posedge clock)
	begin
		rsp.tag <= ringIn.seq[7:0];
		rsp.data <= ringIn.data;
	end

endmodule

//--- ringMmioBridge.sv
// Ring stop that runs quad and long load/store messages as MMIO transactions
// and sends an ok-load response back to the sender; busy means pass-through.
`timescale 1ns/10ps

module ringMmioBridge
	import ringBusPkg::*;
	import mmioBusPkg::*;
(
	input logic clock,
	input logic reset,
	input ringMsg_t ringIn,
	output ringMsg_t ringOut,
	output mmioReq_t mmioReq,
	input logic [1:0] mmioOk,
	input logic [63:0] mmioRdata
);

	logic [4:0] inMmioOpm;
	logic inIdle;
	logic inMmio;

	logic reqLive;
	logic [15:0] reqSeq;
	logic [7:0] reqOpmHi;
	logic [31:0] reqAddr;
	logic [63:0] reqData;
	logic [4:0] reqMmioOpm;

	logic [1:0] okQ; // registered bus inputs
	logic [63:0] rdataQ;

	logic respDone;
	logic rspSent;
	logic [63:0] respData;

	mmioReq_t mmioStage;
	mmioReq_t mmioStageNxt;

	logic acceptReq;
	logic captureRsp;
	logic sendRsp;
	logic releaseReq;
	ringMsg_t rspMsg;

	always_comb
	begin
		case (ringIn.opm[7:0])
			ringOpmLdsq: inMmioOpm = mmioOpmRdQ;
			ringOpmLdsl: inMmioOpm = mmioOpmRdL;
			ringOpmStsq: inMmioOpm = mmioOpmWrQ;
			ringOpmStsl: inMmioOpm = mmioOpmWrL;
			default: inMmioOpm = mmioOpmReady; // ldx, stx, pfx and responses pass on
		endcase
	end

	assign inIdle = ringIn.opm[7:0] == ringOpmIdle;
	assign inMmio = inMmioOpm != mmioOpmReady;

	assign acceptReq = inMmio && !reqLive;
	assign captureRsp = (okQ == mmioOkOk) && !respDone;
	assign sendRsp = respDone && !rspSent && inIdle;
	assign releaseReq = respDone && rspSent && (okQ == mmioOkReady);

	assign rspMsg.seq = reqSeq;
	assign rspMsg.opm = {reqOpmHi, ringOpmOkld};
	assign rspMsg.addr = reqAddr;
	assign rspMsg.data = respData;

	// first MMIO output stage
	always_comb
	begin
		mmioStageNxt = mmioStage;
		if (respDone || (okQ == mmioOkOk))
		begin
			mmioStageNxt.opm = mmioOpmReady;
		end
		else if ((okQ == mmioOkReady) && reqLive)
		begin
			mmioStageNxt.opm = reqMmioOpm;
			mmioStageNxt.addr = reqAddr;
			mmioStageNxt.data = reqData;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			reqLive <= 1'b0;
			respDone <= 1'b0;
			rspSent <= 1'b0;
			okQ <= mmioOkReady;
			mmioStage <= '{opm: mmioOpmReady, addr: '0, data: '0};
			mmioReq <= '{opm: mmioOpmReady, addr: '0, data: '0};
			ringOut <= ringMsgIdle;
		end
		else
		begin
			okQ <= mmioOk;
			mmioStage <= mmioStageNxt;
			mmioReq <= mmioStage; // second stage drives the bus

			if (acceptReq)
				reqLive <= 1'b1;
			else if (releaseReq)
				reqLive <= 1'b0;

			if (captureRsp)
				respDone <= 1'b1;
			else if (releaseReq)
				respDone <= 1'b0;

			if (sendRsp)
				rspSent <= 1'b1;
			else if (releaseReq)
				rspSent <= 1'b0;

			if (acceptReq)
				ringOut <= ringMsgIdle; // request taken off the ring
			else if (sendRsp)
				ringOut <= rspMsg;
			else
				ringOut <= ringIn;
		end
	end

	always_ff @(posedge clock)
	begin
		rdataQ <= mmioRdata;
		if (acceptReq)
		begin
			reqSeq <= ringIn.seq;
			reqOpmHi <= ringIn.opm[15:8];
			reqAddr <= ringIn.addr;
			reqData <= ringIn.data;
			reqMmioOpm <= inMmioOpm;
		end
		if (captureRsp)
			respData <= rdataQ;
	end

endmodule

//--- mmioRegisterBank.sv
// MMIO device with sixteen 64-bit registers.
// Answers each request with hold for a pseudo-random 1 to 4 cycles, then ok.
`timescale 1ns/10ps

module mmioRegisterBank
	import mmioBusPkg::*;
(
	input logic clock,
	input logic reset,
	input mmioReq_t mmioReq,
	output logic [1:0] mmioOk,
	output logic [63:0] mmioRdata
);

	logic [63:0] regs [mmioRegCount];
	logic [3:0] lfsr;
	logic [3:0] holdLeft; // hold cycles still to go
	logic [mmioRegIdxBits-1:0] regIdx;
	logic mapped;
	logic isWrite;
	logic isLong;
	logic startReq;
	logic finish;
	logic [63:0] wrValue;
	logic [63:0] rdValue;

	assign regIdx = mmioReq.addr[3 +: mmioRegIdxBits];
	assign mapped = mmioReq.addr[31:12] == mmioBankBase;
	assign isWrite = (mmioReq.opm == mmioOpmWrQ) || (mmioReq.opm == mmioOpmWrL);
	assign isLong = (mmioReq.opm == mmioOpmRdL) || (mmioReq.opm == mmioOpmWrL);

	assign wrValue = isLong ? {32'h0, mmioReq.data[31:0]} : mmioReq.data;
	assign rdValue = isLong ? {32'h0, regs[regIdx][31:0]} : regs[regIdx];

	assign startReq = (mmioOk == mmioOkReady) && (mmioReq.opm != mmioOpmReady);
	assign finish = (mmioOk == mmioOkHold) && (holdLeft == 4'd1);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			mmioOk <= mmioOkReady;
			lfsr <= 4'b0001;
			holdLeft <= 4'd0;
			for (int i = 0; i < mmioRegCount; i++)
				regs[i] <= 64'h0;
		end
		else
		begin
			lfsr <= {lfsr[2:0], lfsr[3] ^ lfsr[2]}; // x^4 + x^3 + 1
			case (mmioOk)
				mmioOkReady:
				begin
					if (startReq)
					begin
						mmioOk <= mmioOkHold;
						holdLeft <= 4'(lfsr % mmioMaxDelay) + 4'd1;
					end
				end
				mmioOkHold:
				begin
					if (finish)
					begin
						mmioOk <= mmioOkOk;
						if (mapped && isWrite)
							regs[regIdx] <= wrValue;
					end
					else
						holdLeft <= holdLeft - 4'd1;
				end
				mmioOkOk:
				begin
					if (mmioReq.opm == mmioOpmReady)
						mmioOk <= mmioOkReady; // requester saw the answer
				end
				default: mmioOk <= mmioOkReady;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (finish)
		begin
			if (!mapped)
				mmioRdata <= '1; // unmapped reads as all ones
			else if (isWrite)
				mmioRdata <= wrValue;
			else
				mmioRdata <= rdValue;
		end
	end

endmodule

//--- ringMmioTop.sv
// Top level: a two-stop ring closed through the requester and the MMIO bridge,
// with the register bank on the bridge's MMIO bus.
`timescale 1ns/10ps

module ringMmioTop
	import ringBusPkg::*;
	import mmioBusPkg::*;
(
	input logic clock,
	input logic reset,
	input logic cmdValid,
	input ringCmd_t cmd,
	output logic cmdReady,
	output ringRsp_t rsp,
	output logic rspValid
);

	ringMsg_t ringToBridge;
	ringMsg_t ringToRequester;
	mmioReq_t mmioReq;
	logic [1:0] mmioOk;
	logic [63:0] mmioRdata;

	ringRequester u_ringRequester (
		.clock(clock),
		.reset(reset),
		.cmdValid(cmdValid),
		.cmd(cmd),
		.cmdReady(cmdReady),
		.rsp(rsp),
		.rspValid(rspValid),
		.ringIn(ringToRequester),
		.ringOut(ringToBridge)
	);

	ringMmioBridge u_ringMmioBridge (
		.clock(clock),
		.reset(reset),
		.ringIn(ringToBridge),
		.ringOut(ringToRequester),
		.mmioReq(mmioReq),
		.mmioOk(mmioOk),
		.mmioRdata(mmioRdata)
	);

	mmioRegisterBank u_mmioRegisterBank (
		.clock(clock),
		.reset(reset),
		.mmioReq(mmioReq),
		.mmioOk(mmioOk),
		.mmioRdata(mmioRdata)
	);

endmodule

//--- ringMmioTbModel.svh
// Register model and tag scoreboard for the ring MMIO testbench.
// Included inside the testbench module, after its abort task.
`ifndef RING_MMIO_TB_MODEL_SVH
`define RING_MMIO_TB_MODEL_SVH

logic [63:0] modelRegs [mmioRegCount];
ringRsp_t expRsp [ringTagCount]; // expected reply per tag
logic [ringTagCount-1:0] tagBusy;
logic [mmioRegIdxBits-1:0] tagReg [ringTagCount];
logic tagMapped [ringTagCount];

function automatic int lowestFreeTag();
	for (int i = 0; i < ringTagCount; i++)
		if (!tagBusy[i])
			return i;
	return -1;
endfunction

function automatic logic regInFlight(input logic [mmioRegIdxBits-1:0] idx);
	for (int i = 0; i < ringTagCount; i++)
		if (tagBusy[i] && tagMapped[i] && (tagReg[i] == idx))
			return 1'b1;
	return 1'b0;
endfunction

task automatic compareRsp(input ringRsp_t got, input ringRsp_t exp);
	if (got !== exp)
		abortRun($sformatf("mismatch at %0t: tag %0d data %h, expected tag %0d data %h",
			$time, got.tag, got.data, exp.tag, exp.data));
endtask

task automatic compareIdle(input logic validGot, input logic readyGot);
	if ((validGot !== 1'b0) || (readyGot !== 1'b1))
		abortRun($sformatf("mismatch at %0t: rspValid %b cmdReady %b, expected 0 and 1",
			$time, validGot, readyGot));
endtask

// accepted command updates the image in acceptance order
task automatic recordCmd(input ringCmd_t c);
	int tag;
	logic [mmioRegIdxBits-1:0] idx;
	logic mapped;
	ringRsp_t exp;
	tag = lowestFreeTag();
	idx = c.addr[6:3];
	mapped = c.addr[31:12] == mmioBankBase;
	if (tag < 0)
		abortRun("a command was accepted while every tag was in flight");
	if (mapped && c.write)
		modelRegs[idx] = c.isLong ? {32'h0, c.data[31:0]} : c.data;
	exp.tag = 8'(tag);
	if (!mapped)
		exp.data = '1; // unmapped reads as all ones
	else
		exp.data = c.isLong ? {32'h0, modelRegs[idx][31:0]} : modelRegs[idx];
	expRsp[tag] = exp;
	tagBusy[tag] = 1'b1;
	tagReg[tag] = idx;
	tagMapped[tag] = mapped;
endtask

task automatic retireRsp(input ringRsp_t got);
	if ((got.tag >= ringTagCount) || !tagBusy[got.tag[ringTagBits-1:0]])
		abortRun($sformatf("a response came back for tag %0d, which is not outstanding", got.tag));
	compareRsp(got, expRsp[got.tag[ringTagBits-1:0]]);
	tagBusy[got.tag[ringTagBits-1:0]] = 1'b0;
endtask

`endif

//--- ringMmioTb.sv
// Testbench for the ring MMIO subsystem: seeded random loads and stores,
// each response checked by tag against a register model.
`timescale 1ns/10ps

module ringMmioTb
	import ringBusPkg::*;
	import mmioBusPkg::*;
();

	localparam int cmdCount = 400;
	localparam int clockPeriod = 40;
	// a third request can fill both ring slots while the bridge waits to reply
	localparam int maxInFlight = 2;

	logic clock;
	logic reset;
	logic cmdValid;
	ringCmd_t cmd;
	logic cmdReady;
	ringRsp_t rsp;
	logic rspValid;
	int issued;
	int seedInit;

	ringMmioTop u_ringMmioTop (
		.clock(clock),
		.reset(reset),
		.cmdValid(cmdValid),
		.cmd(cmd),
		.cmdReady(cmdReady),
		.rsp(rsp),
		.rspValid(rspValid)
	);

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "stopped at first error");
	endtask

	`include "ringMmioTbModel.svh"

	function automatic ringCmd_t randomCmd();
		ringCmd_t c;
		logic [mmioRegIdxBits-1:0] idx;
		c.write = 1'($urandom);
		c.isLong = 1'($urandom);
		c.data = {$urandom, $urandom};
		do
			idx = mmioRegIdxBits'($urandom % mmioRegCount);
		while (regInFlight(idx)); // keeps per-tag expectations exact
		c.addr = {mmioBankBase, 5'($urandom), idx, 3'b000};
		if ($urandom % 10 == 0)
			c.addr[31:12] = mmioBankBase ^ (20'($urandom) | 20'h1); // off the bank
		return c;
	endfunction

	always #(clockPeriod / 2) clock = ~clock;

	always @(negedge clock)
	begin
		if (!reset)
		begin
			if (rspValid)
				retireRsp(rsp); // frees a tag before a same-cycle accept
			if (cmdValid && cmdReady)
				recordCmd(cmd);
		end
	end

	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		cmdValid = 1'b0;
		cmd = '0;
		tagBusy = '0;
		issued = 0;
		seedInit = $urandom(55963);
		for (int i = 0; i < mmioRegCount; i++)
			modelRegs[i] = 64'h0;
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		compareIdle(rspValid, cmdReady);
		@(posedge clock);
		while (issued < cmdCount)
		begin
			if ($urandom % 4 == 0)
				repeat ($urandom % 4) @(posedge clock); // idle gap
			while ($countones(tagBusy) >= maxInFlight)
				@(posedge clock);
			cmdValid <= 1'b1;
			cmd <= randomCmd();
			do
				@(negedge clock);
			while (!cmdReady);
			issued++;
			@(posedge clock);
			cmdValid <= 1'b0;
		end
		while (tagBusy != '0)
			@(posedge clock);
		repeat (4) @(negedge clock);
		compareIdle(rspValid, cmdReady); // all tags back, ring quiet
		$display("TESTBENCH PASSED");
		$finish;
	end

	initial
	begin
		#(cmdCount * 40 * clockPeriod);
		abortRun("watchdog timeout: the run did not finish in time");
	end

endmodule

//--- ringMmioTop.f
+incdir+.
ringBusPkg.sv
mmioBusPkg.sv
ringRequester.sv
ringMmioBridge.sv
mmioRegisterBank.sv
ringMmioTop.sv
ringMmioTb.sv

//--- Bender.yml
package:
  name: ringMmio

sources:
  - ringBusPkg.sv
  - mmioBusPkg.sv
  - ringRequester.sv
  - ringMmioBridge.sv
  - mmioRegisterBank.sv
  - ringMmioTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - ringMmioTb.sv
